// File: source/icache_settings.svh
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// ====================
// address split
// ====================
// tag 31..11, index 10..3, bit 2 picks the instruction
`define ICACHE_ADDR_W    32
`define ICACHE_OFFSET_W  3
`define ICACHE_INDEX_W   8
`define ICACHE_TAG_W     21

// geometry
`define ICACHE_SETS      256
`define ICACHE_WAYS      2
`define ICACHE_BEAT_W    64
`define ICACHE_INST_W    32

// addi x0, x0, 0
`define ICACHE_NOP       32'h00000013

// read channel codes
`define AXI_RESP_W       2
`define AXI_ID_W         4
`define AXI_RESP_OKAY    2'b00
`define AXI_FETCH_ID     4'h0

`endif

// File: source/icache_pkg.sv
`include "icache_settings.svh"

package icache_pkg;

    // one fetched block
    // word is the raw view, inst[1] is the upper half
    typedef union packed {
        logic [`ICACHE_BEAT_W-1:0] word;
        logic [`ICACHE_BEAT_W/`ICACHE_INST_W-1:0][`ICACHE_INST_W-1:0] inst;
    } axi_beat_t;

endpackage

// File: source/icache_tag_store.sv
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_tag_store (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`ICACHE_ADDR_W-1:0] req_addr,
    input  logic                      fill_en,
    output logic                      hit,
    output logic                      hit_way,
    output logic                      fill_way
);

    logic [`ICACHE_TAG_W-1:0]                tag_mem [`ICACHE_WAYS][`ICACHE_SETS];
    logic [`ICACHE_WAYS-1:0][`ICACHE_SETS-1:0] valid;
    logic [`ICACHE_SETS-1:0]                 victim;

    logic [`ICACHE_INDEX_W-1:0] index;
    logic [`ICACHE_TAG_W-1:0]   tag;
    logic [`ICACHE_WAYS-1:0]    way_hit;
    logic                       set_full;

    assign index = req_addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    assign tag   = req_addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];

    // ====================
    // lookup
    // ====================
    always_comb begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            way_hit[w] = valid[w][index] && (tag_mem[w][index] == tag);
        end
    end

    assign hit = |way_hit;

    // way 0 wins a double match
    assign hit_way = way_hit[1] & ~way_hit[0];

    // ====================
    // victim choice
    // ====================
    assign set_full = valid[0][index] & valid[1][index];

    always_comb begin
        if (!valid[0][index]) begin
            fill_way = 1'b0;
        end else if (!valid[1][index]) begin
            fill_way = 1'b1;
        end else begin
            fill_way = victim[index];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid  <= '0;
            victim <= '0;
        end else if (fill_en) begin
            valid[fill_way][index] <= 1'b1;
            // rotate only once both ways are in use
            if (set_full) begin
                victim[index] <= ~victim[index];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_mem[fill_way][index] <= tag;
        end
    end

endmodule

// File: source/icache_data_store.sv
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_data_store
    import icache_pkg::*;
(
    input  logic                      clk,
    input  logic                      lookup_en,
    input  logic [`ICACHE_ADDR_W-1:0] lookup_addr,
    input  logic                      fill_en,
    input  logic [`ICACHE_ADDR_W-1:0] req_addr,
    input  logic                      fill_way,
    input  axi_beat_t                 fill_beat,
    output axi_beat_t                 rd_beat0,
    output axi_beat_t                 rd_beat1
);

    logic [`ICACHE_BEAT_W-1:0] block_mem [`ICACHE_WAYS][`ICACHE_SETS];

    logic [`ICACHE_INDEX_W-1:0] rd_index;
    logic [`ICACHE_INDEX_W-1:0] wr_index;

    assign rd_index = lookup_addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    assign wr_index = req_addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];

    // both ways read together, way picked later by hit_way
    always_ff @(posedge clk) begin
        if (lookup_en) begin
            rd_beat0.word <= block_mem[0][rd_index];
            rd_beat1.word <= block_mem[1][rd_index];
        end
    end

    // refill write
    always_ff @(posedge clk) begin
        if (fill_en) begin
            block_mem[fill_way][wr_index] <= fill_beat.word;
        end
    end

endmodule

// File: source/icache_miss_ctrl.sv
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_miss_ctrl
    import icache_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      miss_start,
    input  logic                      abandon,
    input  logic [`ICACHE_ADDR_W-1:0] req_addr,
    input  logic                      arready,
    input  logic                      rvalid,
    input  logic [`ICACHE_BEAT_W-1:0] rdata,
    input  logic [`AXI_RESP_W-1:0]    rresp,
    input  logic [`AXI_ID_W-1:0]      rid,
    output logic                      arvalid,
    output logic [`ICACHE_ADDR_W-1:0] araddr,
    output logic                      rready,
    output logic                      busy,
    output logic                      fill_en,
    output logic                      done,
    output axi_beat_t                 beat,
    output logic                      error
);

    localparam logic [1:0] M_IDLE = 2'd0;
    localparam logic [1:0] M_REQ  = 2'd1;
    localparam logic [1:0] M_WAIT = 2'd2;

    logic [1:0] state;
    logic       beat_hs;
    logic       beat_bad;

    assign arvalid = (state == M_REQ);
    assign rready  = (state == M_WAIT);
    assign busy    = (state != M_IDLE);

    assign beat_hs  = rvalid & rready;
    assign beat_bad = (rresp != `AXI_RESP_OKAY) || (rid != `AXI_FETCH_ID);

    assign done    = beat_hs;
    assign fill_en = beat_hs & ~beat_bad;
    assign beat    = rdata;

    // ====================
    // read FSM
    // ====================
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= M_IDLE;
        end else begin
            case (state)
                M_IDLE: begin
                    if (miss_start) begin
                        state <= M_REQ;
                    end
                end
                M_REQ: begin
                    // an accepted address still owes us a beat
                    if (arready) begin
                        state <= M_WAIT;
                    end else if (abandon) begin
                        state <= M_IDLE;
                    end
                end
                M_WAIT: begin
                    if (rvalid) begin
                        state <= M_IDLE;
                    end
                end
                default: state <= M_IDLE;
            endcase
        end
    end

    // block aligned
    always_ff @(posedge clk) begin
        if (state == M_IDLE && miss_start) begin
            araddr <= {req_addr[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            error <= 1'b0;
        end else if (beat_hs) begin
            error <= beat_bad;
        end
    end

endmodule

// File: source/icache_fetch_ctrl.sv
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_fetch_ctrl
    import icache_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`ICACHE_ADDR_W-1:0] pc,
    input  logic                      stall,
    input  logic                      flush,
    input  logic                      hit,
    input  logic                      hit_way,
    input  axi_beat_t                 rd_beat0,
    input  axi_beat_t                 rd_beat1,
    input  logic                      busy,
    input  logic                      done,
    input  axi_beat_t                 beat,
    output logic                      lookup_en,
    output logic [`ICACHE_ADDR_W-1:0] lookup_addr,
    output logic [`ICACHE_ADDR_W-1:0] req_addr,
    output logic                      miss_start,
    output logic                      abandon,
    output logic [`ICACHE_INST_W-1:0] inst,
    output logic                      inst_valid
);

    localparam logic [1:0] F_IDLE   = 2'd0;
    localparam logic [1:0] F_LOOKUP = 2'd1;
    localparam logic [1:0] F_REFILL = 2'd2;

    logic [1:0] state;
    logic       flush_take;
    logic       accept;
    logic       inst_sel;
    axi_beat_t  hit_beat;

    assign flush_take = flush & ~stall;

    // flush wins over a new fetch on the same edge
    assign accept = (state == F_IDLE) & ~busy & ~stall & ~flush;

    assign lookup_en   = accept;
    assign lookup_addr = pc;
    assign abandon     = flush_take;
    assign miss_start  = (state == F_LOOKUP) & ~hit & ~flush_take;

    assign inst_sel = req_addr[`ICACHE_OFFSET_W-1];
    assign hit_beat = hit_way ? rd_beat1 : rd_beat0;

    // ====================
    // fetch FSM
    // ====================
    always_ff @(posedge clk) begin
        if (rst || flush_take) begin
            state      <= F_IDLE;
            inst       <= `ICACHE_NOP;
            inst_valid <= 1'b1;
        end else begin
            case (state)
                F_IDLE: begin
                    if (accept) begin
                        state      <= F_LOOKUP;
                        inst_valid <= 1'b0;
                    end
                end
                F_LOOKUP: begin
                    if (hit) begin
                        state      <= F_IDLE;
                        inst       <= hit_beat.inst[inst_sel];
                        inst_valid <= 1'b1;
                    end else begin
                        state <= F_REFILL;
                    end
                end
                F_REFILL: begin
                    if (done) begin
                        state      <= F_IDLE;
                        inst       <= beat.inst[inst_sel];
                        inst_valid <= 1'b1;
                    end
                end
                default: state <= F_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr <= pc;
        end
    end

endmodule

// File: source/icache_top.sv
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_top
    import icache_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`ICACHE_ADDR_W-1:0] pc,
    input  logic                      stall,
    input  logic                      flush,
    output logic [`ICACHE_INST_W-1:0] inst,
    output logic                      inst_valid,
    output logic                      error,
    output logic                      arvalid,
    output logic [`ICACHE_ADDR_W-1:0] araddr,
    output logic                      rready,
    input  logic                      arready,
    input  logic                      rvalid,
    input  logic [`ICACHE_BEAT_W-1:0] rdata,
    input  logic [`AXI_RESP_W-1:0]    rresp,
    input  logic [`AXI_ID_W-1:0]      rid
);

    logic                      lookup_en;
    logic [`ICACHE_ADDR_W-1:0] lookup_addr;
    logic [`ICACHE_ADDR_W-1:0] req_addr;
    logic                      hit;
    logic                      hit_way;
    logic                      fill_way;
    logic                      miss_start;
    logic                      abandon;
    logic                      busy;
    logic                      fill_en;
    logic                      done;
    axi_beat_t                 beat;
    axi_beat_t                 rd_beat0;
    axi_beat_t                 rd_beat1;

    icache_tag_store u_tag_store (
        .clk      (clk),
        .rst      (rst),
        .req_addr (req_addr),
        .fill_en  (fill_en),
        .hit      (hit),
        .hit_way  (hit_way),
        .fill_way (fill_way)
    );

    icache_data_store u_data_store (
        .clk         (clk),
        .lookup_en   (lookup_en),
        .lookup_addr (lookup_addr),
        .fill_en     (fill_en),
        .req_addr    (req_addr),
        .fill_way    (fill_way),
        .fill_beat   (beat),
        .rd_beat0    (rd_beat0),
        .rd_beat1    (rd_beat1)
    );

    icache_miss_ctrl u_miss_ctrl (
        .clk        (clk),
        .rst        (rst),
        .miss_start (miss_start),
        .abandon    (abandon),
        .req_addr   (req_addr),
        .arready    (arready),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .rresp      (rresp),
        .rid        (rid),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .rready     (rready),
        .busy       (busy),
        .fill_en    (fill_en),
        .done       (done),
        .beat       (beat),
        .error      (error)
    );

    icache_fetch_ctrl u_fetch_ctrl (
        .clk         (clk),
        .rst         (rst),
        .pc          (pc),
        .stall       (stall),
        .flush       (flush),
        .hit         (hit),
        .hit_way     (hit_way),
        .rd_beat0    (rd_beat0),
        .rd_beat1    (rd_beat1),
        .busy        (busy),
        .done        (done),
        .beat        (beat),
        .lookup_en   (lookup_en),
        .lookup_addr (lookup_addr),
        .req_addr    (req_addr),
        .miss_start  (miss_start),
        .abandon     (abandon),
        .inst        (inst),
        .inst_valid  (inst_valid)
    );

endmodule

// File: bench/tb_axi_mem.sv
`timescale 1ns/1ps

module tb_axi_mem (
    input  logic        clk,
    input  logic        rst,
    input  logic        arvalid,
    input  logic [31:0] araddr,
    input  logic        rready,
    output logic        arready,
    output logic        rvalid,
    output logic [63:0] rdata,
    output logic [1:0]  rresp,
    output logic [3:0]  rid
);

    localparam logic [31:0] PATTERN = 32'h5a5a_0000;
    localparam logic [1:0]  SLVERR  = 2'b10;

    logic [31:0] addr;
    int          delay;

    // ====================
    // single beat read slave
    // ====================
    initial begin
        void'($urandom(32'h03d7fd18));
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
        rresp   = '0;
        rid     = '0;
        forever begin
            @(negedge clk);
            if (!rst && arvalid) begin
                delay = $urandom % 6;
                repeat (delay) @(negedge clk);
                // request may have been dropped meanwhile
                if (arvalid) begin
                    addr    = araddr;
                    arready = 1'b1;
                    @(negedge clk);
                    arready = 1'b0;
                    delay = $urandom % 6;
                    repeat (delay) @(negedge clk);
                    rdata  = {(addr + 32'd4) ^ PATTERN, addr ^ PATTERN};
                    // upper half of the map is an error region
                    rresp  = addr[31] ? SLVERR : 2'b00;
                    rid    = '0;
                    rvalid = 1'b1;
                    @(negedge clk);
                    rvalid = 1'b0;
                end
            end
        end
    end

endmodule

// File: bench/tb_icache.sv
`timescale 1ns/1ps
`include "icache_settings.svh"

module tb_icache;

    localparam int MAX_ROWS = 64;
    localparam int TIMEOUT  = 200;

    logic        clk;
    logic        rst;
    logic [31:0] pc;
    logic        stall;
    logic        flush;
    logic [31:0] inst;
    logic        inst_valid;
    logic        error;
    logic        arvalid;
    logic [31:0] araddr;
    logic        rready;
    logic        arready;
    logic        rvalid;
    logic [63:0] rdata;
    logic [1:0]  rresp;
    logic [3:0]  rid;

    // five words per row in the order pc mode inst miss error
    logic [31:0] golden [5*MAX_ROWS];
    int          rows;

    initial clk = 1'b0;
    always #4 clk = ~clk;

    icache_top u_dut (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .stall      (stall),
        .flush      (flush),
        .inst       (inst),
        .inst_valid (inst_valid),
        .error      (error),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .rready     (rready),
        .arready    (arready),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .rresp      (rresp),
        .rid        (rid)
    );

    tb_axi_mem u_mem (
        .clk     (clk),
        .rst     (rst),
        .arvalid (arvalid),
        .araddr  (araddr),
        .rready  (rready),
        .arready (arready),
        .rvalid  (rvalid),
        .rdata   (rdata),
        .rresp   (rresp),
        .rid     (rid)
    );

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("Mismatch at %0t: %s, got %h, expected %h",
                                    $time, what, got, exp));
        end
    endtask

    task automatic wait_for_idle();
        int n;
        n = 0;
        while (!inst_valid) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                stop_on_error("timeout while waiting for the cache to go idle");
            end
        end
    endtask

    // ====================
    // one golden row
    // ====================
    task automatic run_row(input int row);
        logic [31:0] mode;
        int          reads;
        int          beats;
        int          lat;
        logic        prev_ar;
        logic        prev_r;
        mode  = golden[5*row+1];
        reads = 0;
        beats = 0;
        lat   = 0;
        wait_for_idle();
        if (mode == 32'd0) begin
            pc    = golden[5*row];
            stall = 1'b0;
        end else begin
            flush = 1'b1;
            stall = (mode == 32'd2);
        end
        @(negedge clk);
        flush = 1'b0;
        stall = 1'b1;
        if (mode == 32'd0) begin
            check_value(32'(inst_valid), 32'd0, "inst_valid after acceptance");
            prev_ar = arvalid;
            prev_r  = rready;
            while (!inst_valid) begin
                @(negedge clk);
                lat++;
                if (arvalid && !prev_ar) begin
                    reads++;
                    // request goes out on the aligned block address
                    check_value(araddr, golden[5*row] & 32'hffff_fff8, "araddr");
                end
                if (rready && !prev_r) begin
                    beats++;
                end
                prev_ar = arvalid;
                prev_r  = rready;
                if (lat > TIMEOUT) begin
                    stop_on_error("timeout while waiting for inst_valid after a fetch");
                end
            end
            // a hit answers on the edge after acceptance
            if (golden[5*row+3] == 32'd0) begin
                check_value(32'(lat), 32'd1, "hit latency in cycles");
            end
            check_value(32'(reads), golden[5*row+3], "read count");
            check_value(32'(beats), golden[5*row+3], "rready assertions");
            check_value(32'(rready), 32'd0, "rready after fetch");
        end else begin
            check_value(32'(arvalid), 32'd0, "arvalid after flush");
        end
        check_value(32'(inst_valid), 32'd1, "inst_valid");
        check_value(inst, golden[5*row+2], "inst");
        check_value(32'(error), golden[5*row+4], "error");
    endtask

    initial begin
        rst   = 1'b1;
        pc    = '0;
        stall = 1'b1;
        flush = 1'b0;
        for (int i = 0; i < 5*MAX_ROWS; i++) begin
            golden[i] = '1;
        end
        $readmemh("bench/golden_fetch.hex", golden);
        repeat (4) @(negedge clk);
        rst = 1'b0;

        check_value(inst, `ICACHE_NOP, "inst after reset");
        check_value(32'(inst_valid), 32'd1, "inst_valid after reset");
        check_value(32'(arvalid), 32'd0, "arvalid after reset");
        check_value(32'(rready), 32'd0, "rready after reset");
        check_value(32'(error), 32'd0, "error after reset");

        rows = 0;
        while (rows < MAX_ROWS && golden[5*rows+1] != 32'hffff_ffff) begin
            run_row(rows);
            rows++;
        end
        if (rows == 0) begin
            stop_on_error("golden file holds no rows");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

// File: bench/golden_fetch.hex
// pc mode inst miss error, one fetch or flush per line
// mode 0 fetch, 1 flush, 2 flush with stall high
00001000 0 5a5a1000 1 0
00001000 0 5a5a1000 0 0
00001004 0 5a5a1004 0 0
0000200c 0 5a5a200c 1 0
00002008 0 5a5a2008 0 0
00000080 0 5a5a0080 1 0
00000884 0 5a5a0884 1 0
00001080 0 5a5a1080 1 0
00000880 0 5a5a0880 0 0
00000084 0 5a5a0084 1 0
00001084 0 5a5a1084 0 0
80000100 0 da5a0100 1 1
80000100 0 da5a0100 1 1
00003010 0 5a5a3010 1 0
00000000 1 00000013 0 0
00003014 0 5a5a3014 0 0
00000000 2 5a5a3014 0 0
00000000 1 00000013 0 0
12345678 0 486e5678 1 0
1234567c 0 486e567c 0 0
00000080 0 5a5a0080 0 0
7ffffff8 0 25a5fff8 1 0
7ffffffc 0 25a5fffc 0 0
0000200c 0 5a5a200c 0 0
00002800 0 5a5a2800 1 0
00001000 0 5a5a1000 0 0
00002804 0 5a5a2804 0 0
00000000 1 00000013 0 0

// File: flist.f
+incdir+source
source/icache_pkg.sv
source/icache_tag_store.sv
source/icache_data_store.sv
source/icache_miss_ctrl.sv
source/icache_fetch_ctrl.sv
source/icache_top.sv
bench/tb_axi_mem.sv
bench/tb_icache.sv

// File: run_sim.sh
#!/bin/sh
# build and run the icache testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps --top-module tb_icache -f flist.f \
    && ./obj_dir/Vtb_icache \
    || exit 1
